// File: fpu_div.f
hw/fpu_div_pkg.sv
hw/fdiv_mant_pipe.sv
hw/fdiv_round.sv
hw/pe_serializer.sv
hw/skid_buffer.sv
hw/fpu_div.sv
+incdir+sim
sim/fpu_div_tb.sv

// File: hw/fdiv_mant_pipe.sv
// fdiv_mant_pipe: operand unpack, special-case classification and radix-4 mantissa divider
`default_nettype none

module fdiv_mant_pipe import fpu_div_pkg::*; (
    input  wire                     clk,
    input  wire                     enable,
    input  wire [31:0]              a_in,
    input  wire [31:0]              b_in,
    input  wire frm_e               frm_in,
    output logic                    sign,
    output logic                    special,
    output frm_e                    frm_out,
    output logic signed [9:0]       exp,
    output logic [27:0]             quot,
    output logic [31:0]             special_val,
    output logic [FFLAGS_BITS-1:0]  special_flags
);
    localparam int STAGES = LATENCY_FDIV - 2;
    localparam int QW     = 2 * STAGES + 1;
    localparam logic [31:0] QNAN = 32'h7FC0_0000;

    // two restoring steps, returns {quotient bits, new remainder}
    function automatic logic [25:0] r4_step(input logic [23:0] rem, input logic [23:0] d);
        logic [24:0] r;
        logic [1:0]  q;
        r    = {rem, 1'b0};
        q[1] = (r >= {1'b0, d});
        if (q[1]) r = r - {1'b0, d};
        r    = {r[23:0], 1'b0};
        q[0] = (r >= {1'b0, d});
        if (q[0]) r = r - {1'b0, d};
        return {q, r[23:0]};
    endfunction

    logic [7:0]  ea, eb;
    logic [23:0] ma, mb;
    logic        a_zero, a_inf, a_nan, b_zero, b_inf, b_nan;
    logic        s0_special;
    logic [31:0] s0_val;
    logic [FFLAGS_BITS-1:0] s0_flags;

    logic                   sign_q  [0:STAGES];
    logic                   spec_q  [0:STAGES];
    frm_e                   frm_q   [0:STAGES];
    logic signed [9:0]      exp_q   [0:STAGES];
    logic [31:0]            val_q   [0:STAGES];
    logic [FFLAGS_BITS-1:0] flags_q [0:STAGES];
    logic [23:0]            rem_q   [0:STAGES];
    logic [QW-1:0]          q_q     [0:STAGES];
    logic [23:0]            div_q   [0:STAGES-1];
    logic [25:0]            step    [1:STAGES];

    // subnormals count as zero, so only the exponent field decides zero
    always_comb begin
        ea     = a_in[30:23];
        eb     = b_in[30:23];
        ma     = {1'b1, a_in[22:0]};
        mb     = {1'b1, b_in[22:0]};
        a_zero = (ea == 8'd0);
        b_zero = (eb == 8'd0);
        a_inf  = (ea == 8'hFF) && (a_in[22:0] == 23'd0);
        b_inf  = (eb == 8'hFF) && (b_in[22:0] == 23'd0);
        a_nan  = (ea == 8'hFF) && (a_in[22:0] != 23'd0);
        b_nan  = (eb == 8'hFF) && (b_in[22:0] != 23'd0);

        s0_special = 1'b1;
        s0_val     = QNAN;
        s0_flags   = '0;
        if (a_nan || b_nan) begin
            // only a signalling NaN raises invalid
            s0_flags[FLAG_NV] = (a_nan && !a_in[22]) || (b_nan && !b_in[22]);
        end else if ((a_inf && b_inf) || (a_zero && b_zero)) begin
            s0_flags[FLAG_NV] = 1'b1;
        end else if (a_inf || b_zero) begin
            s0_val            = {a_in[31] ^ b_in[31], 8'hFF, 23'd0};
            s0_flags[FLAG_DZ] = b_zero && !a_inf;
        end else if (a_zero || b_inf) begin
            s0_val = {a_in[31] ^ b_in[31], 31'd0};
        end else begin
            s0_special = 1'b0;
        end
    end

    always_comb begin
        for (int k = 1; k <= STAGES; k++) begin
            step[k] = r4_step(rem_q[k-1], div_q[k-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            // stage 0 also resolves the integer quotient bit
            sign_q[0]  <= a_in[31] ^ b_in[31];
            spec_q[0]  <= s0_special;
            frm_q[0]   <= frm_in;
            exp_q[0]   <= $signed({2'b00, ea}) - $signed({2'b00, eb}) + 10'sd127;
            val_q[0]   <= s0_val;
            flags_q[0] <= s0_flags;
            q_q[0]     <= QW'(ma >= mb);
            rem_q[0]   <= (ma >= mb) ? ma - mb : ma;
            div_q[0]   <= mb;
            for (int k = 1; k <= STAGES; k++) begin
                sign_q[k]  <= sign_q[k-1];
                spec_q[k]  <= spec_q[k-1];
                frm_q[k]   <= frm_q[k-1];
                exp_q[k]   <= exp_q[k-1];
                val_q[k]   <= val_q[k-1];
                flags_q[k] <= flags_q[k-1];
                q_q[k]     <= {q_q[k-1][QW-3:0], step[k][25:24]};
                rem_q[k]   <= step[k][23:0];
            end
            for (int k = 1; k < STAGES; k++) begin
                div_q[k] <= div_q[k-1];
            end
        end
    end

    assign sign          = sign_q[STAGES];
    assign special       = spec_q[STAGES];
    assign frm_out       = frm_q[STAGES];
    assign exp           = exp_q[STAGES];
    assign special_val   = val_q[STAGES];
    assign special_flags = flags_q[STAGES];
    // a nonzero final remainder is the sticky bit
    assign quot          = {q_q[STAGES], |rem_q[STAGES]};

endmodule

`default_nettype wire

// File: hw/fdiv_round.sv
// fdiv_round: quotient normalization, rounding, overflow and underflow handling, packing, flags
`default_nettype none

module fdiv_round import fpu_div_pkg::*; (
    input  wire                     clk,
    input  wire                     enable,
    input  wire                     sign,
    input  wire                     special,
    input  wire signed [9:0]        exp,
    input  wire [27:0]              quot,
    input  wire [31:0]              special_val,
    input  wire [FFLAGS_BITS-1:0]   special_flags,
    input  wire frm_e               frm_in,
    output logic [31:0]             result,
    output logic [FFLAGS_BITS-1:0]  flags
);
    logic [23:0]       mant;
    logic              guard, sticky, inexact, round_up, to_inf;
    logic [24:0]       m_rnd;
    logic signed [9:0] e_norm, e_fin;
    logic [31:0]       res_d;
    logic [FFLAGS_BITS-1:0] flags_d;

    always_comb begin
        // quotient lies in [0.5, 2), so at most one left shift is needed
        if (quot[27]) begin
            mant   = quot[27:4];
            guard  = quot[3];
            sticky = |quot[2:0];
            e_norm = exp;
        end else begin
            mant   = quot[26:3];
            guard  = quot[2];
            sticky = |quot[1:0];
            e_norm = exp - 10'sd1;
        end
        inexact = guard | sticky;

        case (frm_in)
            RTZ:     round_up = 1'b0;
            RDN:     round_up = sign & inexact;
            RUP:     round_up = ~sign & inexact;
            RMM:     round_up = guard;
            default: round_up = guard & (sticky | mant[0]);
        endcase

        // a carry out of the mantissa leaves the fraction at zero
        m_rnd = {1'b0, mant} + 25'(round_up);
        e_fin = e_norm + $signed({9'd0, m_rnd[24]});

        // overflow saturates to the largest finite value when rounding toward zero
        case (frm_in)
            RTZ:     to_inf = 1'b0;
            RDN:     to_inf = sign;
            RUP:     to_inf = ~sign;
            default: to_inf = 1'b1;
        endcase

        flags_d = '0;
        if (special) begin
            res_d   = special_val;
            flags_d = special_flags;
        end else if (e_fin > 10'sd254) begin
            res_d            = to_inf ? {sign, 8'hFF, 23'd0} : {sign, 8'hFE, 23'h7FFFFF};
            flags_d[FLAG_OF] = 1'b1;
            flags_d[FLAG_NX] = 1'b1;
        end else if (e_fin < 10'sd1) begin
            res_d            = {sign, 31'd0};
            flags_d[FLAG_UF] = 1'b1;
            flags_d[FLAG_NX] = 1'b1;
        end else begin
            res_d            = {sign, e_fin[7:0], m_rnd[22:0]};
            flags_d[FLAG_NX] = inexact;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= res_d;
            flags  <= flags_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/fpu_div.sv
// fpu_div: multi-lane FP divide top level with lane packing, PE array, output buffer, flag merge
`default_nettype none

module fpu_div import fpu_div_pkg::*; #(
    parameter int NUM_LANES = 4,
    parameter int NUM_PES   = 2,
    parameter int TAG_WIDTH = 4
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         valid_in,
    output logic                        ready_in,
    input  wire [NUM_LANES-1:0]         mask_in,
    input  wire [TAG_WIDTH-1:0]         tag_in,
    input  wire frm_e                   frm,
    input  wire [NUM_LANES-1:0][31:0]   dataa,
    input  wire [NUM_LANES-1:0][31:0]   datab,
    output logic [NUM_LANES-1:0][31:0]  result,
    output logic [FFLAGS_BITS-1:0]      fflags,
    output logic [TAG_WIDTH-1:0]        tag_out,
    output logic                        valid_out,
    input  wire                         ready_out
);
    localparam int TW    = NUM_LANES + TAG_WIDTH;
    localparam int BUF_W = NUM_LANES * PE_OUT_BITS + TW;

    logic [NUM_LANES-1:0][PE_IN_BITS-1:0]  lane_in;
    logic [NUM_LANES-1:0][PE_OUT_BITS-1:0] lane_out;
    logic [NUM_LANES-1:0]                  mask_out;
    wire                                   pe_enable;
    wire  [NUM_PES-1:0][PE_IN_BITS-1:0]    pe_in;
    wire  [NUM_PES-1:0][PE_OUT_BITS-1:0]   pe_out;
    wire                                   ser_valid, ser_ready;
    wire  [NUM_LANES-1:0][PE_OUT_BITS-1:0] ser_data;
    wire  [TW-1:0]                         ser_tag;
    wire  [BUF_W-1:0]                      buf_data;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_in[i] = {frm, datab[i], dataa[i]};
        end
    end

    // the mask rides with the tag so it stays matched to its results
    pe_serializer #(
        .NUM_LANES (NUM_LANES),
        .NUM_PES   (NUM_PES),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_serializer (
        .clk         (clk),
        .reset       (reset),
        .valid_in    (valid_in),
        .ready_in    (ready_in),
        .data_in     (lane_in),
        .tag_in      ({mask_in, tag_in}),
        .pe_enable   (pe_enable),
        .pe_data_out (pe_in),
        .pe_data_in  (pe_out),
        .valid_out   (ser_valid),
        .data_out    (ser_data),
        .tag_out     (ser_tag),
        .ready_out   (ser_ready)
    );

    for (genvar i = 0; i < NUM_PES; i++) begin : g_pe
        logic                   sign, special;
        frm_e                   pe_frm;
        logic signed [9:0]      exp;
        logic [27:0]            quot;
        logic [31:0]            sval;
        logic [FFLAGS_BITS-1:0] sflags;

        fdiv_mant_pipe u_mant (
            .clk (clk), .enable (pe_enable),
            .a_in (pe_in[i][31:0]), .b_in (pe_in[i][63:32]),
            .frm_in (frm_e'(pe_in[i][PE_IN_BITS-1 -: FRM_BITS])),
            .sign (sign), .special (special), .frm_out (pe_frm), .exp (exp), .quot (quot),
            .special_val (sval), .special_flags (sflags)
        );

        fdiv_round u_round (
            .clk (clk), .enable (pe_enable), .sign (sign), .special (special), .exp (exp),
            .quot (quot), .special_val (sval), .special_flags (sflags), .frm_in (pe_frm),
            .result (pe_out[i][31:0]), .flags (pe_out[i][PE_OUT_BITS-1:32])
        );
    end

    skid_buffer #(
        .WIDTH (BUF_W)
    ) u_out_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (ser_valid),
        .ready_in  (ser_ready),
        .data_in   ({ser_tag, ser_data}),
        .valid_out (valid_out),
        .data_out  (buf_data),
        .ready_out (ready_out)
    );

    assign {mask_out, tag_out, lane_out} = buf_data;

    // inactive lanes still compute, but their flags are dropped here
    always_comb begin
        fflags = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            result[i] = lane_out[i][31:0];
            if (mask_out[i]) fflags = fflags | lane_out[i][PE_OUT_BITS-1:32];
        end
    end

endmodule

`default_nettype wire

// File: hw/fpu_div_pkg.sv
// rounding-mode enum, flag layout, PE data widths and divider latency for the divide unit
`default_nettype none

package fpu_div_pkg;

    localparam int FRM_BITS = 3;

    // dynamic rounding modes, encoded as in the instruction frm field
    typedef enum logic [FRM_BITS-1:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } frm_e;

    // exception flags, NV in the MSB down to NX in the LSB
    localparam int FFLAGS_BITS = 5;
    localparam int FLAG_NV     = 4;
    localparam int FLAG_DZ     = 3;
    localparam int FLAG_OF     = 2;
    localparam int FLAG_UF     = 1;
    localparam int FLAG_NX     = 0;

    // one unpack stage, thirteen radix-4 stages and one round stage
    localparam int LATENCY_FDIV = 15;

    // per lane: {frm, divisor, dividend} into a PE and {flags, quotient} back
    localparam int PE_IN_BITS  = 2 * 32 + FRM_BITS;
    localparam int PE_OUT_BITS = 32 + FFLAGS_BITS;

endpackage

`default_nettype wire

// File: hw/pe_serializer.sv
// lane serializer with batching onto the PEs, in-flight tracking, result reassembly and stall
`default_nettype none

module pe_serializer import fpu_div_pkg::*; #(
    parameter int NUM_LANES = 4,
    parameter int NUM_PES   = 2,
    parameter int TAG_WIDTH = 4
) (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire                                       valid_in,
    output logic                                      ready_in,
    input  wire [NUM_LANES-1:0][PE_IN_BITS-1:0]       data_in,
    input  wire [NUM_LANES+TAG_WIDTH-1:0]             tag_in,
    output logic                                      pe_enable,
    output logic [NUM_PES-1:0][PE_IN_BITS-1:0]        pe_data_out,
    input  wire [NUM_PES-1:0][PE_OUT_BITS-1:0]        pe_data_in,
    output logic                                      valid_out,
    output logic [NUM_LANES-1:0][PE_OUT_BITS-1:0]     data_out,
    output logic [NUM_LANES+TAG_WIDTH-1:0]            tag_out,
    input  wire                                       ready_out
);
    localparam int BATCHES = NUM_LANES / NUM_PES;
    localparam int BW      = (BATCHES > 1) ? $clog2(BATCHES) : 1;
    localparam int TW      = NUM_LANES + TAG_WIDTH;
    localparam int TAIL    = LATENCY_FDIV - 1;

    logic [BW-1:0] batch_cnt;
    logic          last_batch;
    logic          issue;

    // in-flight record for every issued batch that moves in step with the PE pipeline
    logic [LATENCY_FDIV-1:0] sr_valid;
    logic [LATENCY_FDIV-1:0] sr_last;
    logic [BW-1:0]           sr_batch [LATENCY_FDIV];
    logic [TW-1:0]           sr_tag   [LATENCY_FDIV];

    // the whole pipeline only moves when the output side can take an entry
    assign pe_enable  = ready_out;
    assign last_batch = (batch_cnt == BW'(BATCHES - 1));
    assign ready_in   = pe_enable & last_batch;
    assign issue      = valid_in & pe_enable;

    always_comb begin
        for (int i = 0; i < NUM_PES; i++) begin
            pe_data_out[i] = data_in[batch_cnt * NUM_PES + i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_cnt <= '0;
        end else if (issue) begin
            batch_cnt <= last_batch ? '0 : batch_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sr_valid <= '0;
            sr_last  <= '0;
        end else if (pe_enable) begin
            sr_valid <= {sr_valid[LATENCY_FDIV-2:0], issue};
            sr_last  <= {sr_last[LATENCY_FDIV-2:0], issue & last_batch};
        end
    end

    always_ff @(posedge clk) begin
        if (pe_enable) begin
            sr_batch[0] <= batch_cnt;
            sr_tag[0]   <= tag_in;
            for (int k = 1; k < LATENCY_FDIV; k++) begin
                sr_batch[k] <= sr_batch[k-1];
                sr_tag[k]   <= sr_tag[k-1];
            end
        end
    end

    // returning slices land in their lanes of the collection register
    // and a write here only happens on an edge where the previous vector is consumed
    always_ff @(posedge clk) begin
        if (pe_enable && sr_valid[TAIL]) begin
            for (int i = 0; i < NUM_PES; i++) begin
                data_out[sr_batch[TAIL] * NUM_PES + i] <= pe_data_in[i];
            end
        end
        if (pe_enable && sr_last[TAIL]) begin
            tag_out <= sr_tag[TAIL];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (pe_enable) begin
            valid_out <= sr_last[TAIL];
        end
    end

endmodule

`default_nettype wire

// File: hw/skid_buffer.sv
// skid_buffer: two-entry register FIFO with a registered ready toward the producer
`default_nettype none

module skid_buffer #(
    parameter int WIDTH = 32
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              valid_in,
    output logic             ready_in,
    input  wire [WIDTH-1:0]  data_in,
    output logic             valid_out,
    output logic [WIDTH-1:0] data_out,
    input  wire              ready_out
);
    logic [WIDTH-1:0] mem [0:1];
    logic [1:0]       count, count_next;
    logic             wr_ptr, rd_ptr;
    logic             push, pop;

    assign push       = valid_in & ready_in;
    assign pop        = valid_out & ready_out;
    assign count_next = count + {1'b0, push} - {1'b0, pop};

    always_ff @(posedge clk) begin
        if (reset) begin
            count    <= 2'd0;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            ready_in <= 1'b0;
        end else begin
            count    <= count_next;
            // ready is a flop so the producer never sees ready_out combinationally
            ready_in <= (count_next != 2'd2);
            if (push) wr_ptr <= ~wr_ptr;
            if (pop)  rd_ptr <= ~rd_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign valid_out = (count != 2'd0);
    assign data_out  = mem[rd_ptr];

endmodule

`default_nettype wire

// File: sim/fpu_div_vectors.svh
// stimulus and expected-value rows for the divide unit testbench
`ifndef FPU_DIV_VECTORS_SVH
`define FPU_DIV_VECTORS_SVH

// columns: row, frm, mask (lane 3 down to lane 0),
// dividends lane 0..3, divisors lane 0..3, expected quotients lane 0..3, merged flags
// flag bits from left to right are NV DZ OF UF NX

task automatic load_vectors();
    // exact and inexact quotients, the last lane overflows
    set_row(0, RNE, 4'b1111,
            32'h40C00000, 32'h3F800000, 32'hC0E00000, 32'h7149F2CA,
            32'h40400000, 32'h40400000, 32'h40000000, 32'h2EDBE6FF,
            32'h40000000, 32'h3EAAAAAB, 32'hC0600000, 32'h7F800000, 5'b00101);
    // 1/3 and -1/3 under each directed mode
    set_row(1, RTZ, 4'b1111,
            32'h3F800000, 32'hBF800000, 32'h40C00000, 32'hC0E00000,
            32'h40400000, 32'h40400000, 32'h40400000, 32'h40000000,
            32'h3EAAAAAA, 32'hBEAAAAAA, 32'h40000000, 32'hC0600000, 5'b00001);
    set_row(2, RDN, 4'b1111,
            32'h3F800000, 32'hBF800000, 32'h40C00000, 32'hC0E00000,
            32'h40400000, 32'h40400000, 32'h40400000, 32'h40000000,
            32'h3EAAAAAA, 32'hBEAAAAAB, 32'h40000000, 32'hC0600000, 5'b00001);
    set_row(3, RUP, 4'b1111,
            32'h3F800000, 32'hBF800000, 32'h40C00000, 32'hC0E00000,
            32'h40400000, 32'h40400000, 32'h40400000, 32'h40000000,
            32'h3EAAAAAB, 32'hBEAAAAAA, 32'h40000000, 32'hC0600000, 5'b00001);
    set_row(4, RMM, 4'b1111,
            32'h3F800000, 32'hBF800000, 32'h40C00000, 32'hC0E00000,
            32'h40400000, 32'h40400000, 32'h40400000, 32'h40000000,
            32'h3EAAAAAB, 32'hBEAAAAAB, 32'h40000000, 32'hC0600000, 5'b00001);
    // 1/0, 0/0, inf/inf and a quiet NaN operand
    set_row(5, RNE, 4'b1111,
            32'h3F800000, 32'h00000000, 32'h7F800000, 32'h7FC00000,
            32'h00000000, 32'h00000000, 32'h7F800000, 32'h3F800000,
            32'h7F800000, 32'h7FC00000, 32'h7FC00000, 32'h7FC00000, 5'b11000);
    // -1/0, inf/2, tiny over huge and a signalling NaN
    set_row(6, RNE, 4'b1111,
            32'hBF800000, 32'h7F800000, 32'h0DA24260, 32'h7F800001,
            32'h00000000, 32'h40000000, 32'h7149F2CA, 32'h3F800000,
            32'hFF800000, 32'h7F800000, 32'h00000000, 32'h7FC00000, 5'b11011);
    // same operands with the divide-by-zero lane masked off
    set_row(7, RNE, 4'b1110,
            32'hBF800000, 32'h7F800000, 32'h0DA24260, 32'h7F800001,
            32'h00000000, 32'h40000000, 32'h7149F2CA, 32'h3F800000,
            32'hFF800000, 32'h7F800000, 32'h00000000, 32'h7FC00000, 5'b10011);
endtask

`endif

// File: sim/fpu_div_tb.sv
// testbench with clock, reset, table-driven driver, in-order output monitor, checks and summary
`default_nettype none

module fpu_div_tb import fpu_div_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LANES  = 4;
    localparam int NUM_PES    = 2;
    localparam int TAG_WIDTH  = 4;
    localparam int NUM_ROWS   = 8;
    localparam int WAIT_LIMIT = 400;

    logic                       clk;
    logic                       reset;
    logic                       valid_in;
    logic                       ready_in;
    logic [NUM_LANES-1:0]       mask_in;
    logic [TAG_WIDTH-1:0]       tag_in;
    frm_e                       frm;
    logic [NUM_LANES-1:0][31:0] dataa;
    logic [NUM_LANES-1:0][31:0] datab;
    logic [NUM_LANES-1:0][31:0] result;
    logic [FFLAGS_BITS-1:0]     fflags;
    logic [TAG_WIDTH-1:0]       tag_out;
    logic                       valid_out;
    logic                       ready_out;

    frm_e                       vec_frm   [NUM_ROWS];
    logic [NUM_LANES-1:0]       vec_mask  [NUM_ROWS];
    logic [NUM_LANES-1:0][31:0] vec_a     [NUM_ROWS];
    logic [NUM_LANES-1:0][31:0] vec_b     [NUM_ROWS];
    logic [NUM_LANES-1:0][31:0] vec_res   [NUM_ROWS];
    logic [FFLAGS_BITS-1:0]     vec_flags [NUM_ROWS];

    // rows and tags of accepted requests that have not come back yet
    int                   pend_row [$];
    logic [TAG_WIDTH-1:0] pend_tag [$];
    logic [TAG_WIDTH-1:0] next_tag;
    int                   errors;
    int                   checks;
    int                   tests;
    int                   lat;
    bit                   burst_done;

    fpu_div #(
        .NUM_LANES (NUM_LANES),
        .NUM_PES   (NUM_PES),
        .TAG_WIDTH (TAG_WIDTH)
    ) dut (
        .clk (clk), .reset (reset), .valid_in (valid_in), .ready_in (ready_in),
        .mask_in (mask_in), .tag_in (tag_in), .frm (frm), .dataa (dataa), .datab (datab),
        .result (result), .fflags (fflags), .tag_out (tag_out), .valid_out (valid_out),
        .ready_out (ready_out)
    );

    `include "fpu_div_vectors.svh"

    task automatic set_row(input int idx, input frm_e f, input logic [3:0] m,
                           input logic [31:0] a0, a1, a2, a3,
                           input logic [31:0] b0, b1, b2, b3,
                           input logic [31:0] r0, r1, r2, r3,
                           input logic [4:0] fl);
        vec_frm[idx]   = f;
        vec_mask[idx]  = m;
        vec_a[idx]     = {a3, a2, a1, a0};
        vec_b[idx]     = {b3, b2, b1, b0};
        vec_res[idx]   = {r3, r2, r1, r0};
        vec_flags[idx] = fl;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("error at %0d ns: %s expected %h got %h", $time, name, expv, actv);
        errors++;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // each accepted output is compared against the oldest pending request
    initial begin
        int row;
        logic [TAG_WIDTH-1:0] etag;
        forever begin
            @(posedge clk);
            if (!reset && valid_out && ready_out) begin
                if (pend_row.size() == 0) begin
                    $display("unexpected result with tag %h at %0d ns", tag_out, $time);
                    errors++;
                end else begin
                    row  = pend_row.pop_front();
                    etag = pend_tag.pop_front();
                    for (int i = 0; i < NUM_LANES; i++) begin
                        if (vec_mask[row][i]) begin
                            checks++;
                            if (result[i] !== vec_res[row][i])
                                report_mismatch($sformatf("result[%0d]", i),
                                                vec_res[row][i], result[i]);
                        end
                    end
                    checks += 2;
                    if (fflags !== vec_flags[row])
                        report_mismatch("fflags", 32'(vec_flags[row]), 32'(fflags));
                    if (tag_out !== etag)
                        report_mismatch("tag_out", 32'(etag), 32'(tag_out));
                end
            end
        end
    end

    // entered 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic apply_row(input int idx);
        int  waited;
        bit  accepted;
        waited   = 0;
        accepted = 0;
        frm      = vec_frm[idx];
        mask_in  = vec_mask[idx];
        dataa    = vec_a[idx];
        datab    = vec_b[idx];
        tag_in   = next_tag;
        valid_in = 1'b1;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            if (ready_in) accepted = 1;
            else waited++;
        end
        if (accepted) begin
            pend_row.push_back(idx);
            pend_tag.push_back(next_tag);
            next_tag++;
        end else begin
            $display("timeout: request for row %0d was never accepted", idx);
            errors++;
        end
        #1;
        valid_in = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pend_row.size() > 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (pend_row.size() > 0) begin
            $display("timeout: %0d results never came back", pend_row.size());
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: done, %0d errors", tests, name, errors - err_before);
    endtask

    initial begin
        int e0;
        errors = 0;
        checks = 0;
        tests = 0;
        next_tag = '0;
        reset = 1'b1;
        valid_in = 1'b0;
        mask_in = '0;
        tag_in = '0;
        frm = RNE;
        dataa = '0;
        datab = '0;
        ready_out = 1'b1;
        load_vectors();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        e0 = errors;
        apply_row(0);
        wait_drain();
        finish_test("rne quotients", e0);

        e0 = errors;
        for (int r = 1; r <= 4; r++) apply_row(r);
        wait_drain();
        finish_test("rounding modes", e0);

        e0 = errors;
        apply_row(5);
        apply_row(6);
        wait_drain();
        finish_test("special cases", e0);

        e0 = errors;
        apply_row(7);
        wait_drain();
        finish_test("lane masking", e0);

        // burst with the output stalled and ready_out toggling every other cycle afterwards
        e0 = errors;
        burst_done = 0;
        fork
            begin
                for (int r = 0; r < NUM_ROWS; r++) apply_row(r);
                burst_done = 1;
            end
            begin
                int guard;
                guard = 0;
                ready_out = 1'b0;
                repeat (30) @(posedge clk);
                while ((!burst_done || pend_row.size() > 0) && guard < 4 * WAIT_LIMIT) begin
                    @(posedge clk);
                    #1;
                    ready_out = ~ready_out;
                    guard++;
                end
                if (guard >= 4 * WAIT_LIMIT) begin
                    $display("timeout: burst did not drain under back-pressure");
                    errors++;
                end
                ready_out = 1'b1;
            end
        join
        wait_drain();
        finish_test("back-pressure ordering", e0);

        // count edges from the accepting edge to the first edge that sees valid_out
        e0 = errors;
        apply_row(0);
        lat = 1;
        @(posedge clk);
        while (!valid_out && lat < WAIT_LIMIT) begin
            @(posedge clk);
            lat++;
        end
        checks++;
        if (lat !== LATENCY_FDIV + NUM_LANES / NUM_PES)
            report_mismatch("latency", 32'(LATENCY_FDIV + NUM_LANES / NUM_PES), 32'(lat));
        #1;
        wait_drain();
        finish_test("latency", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
